// ==== axi_mem_pkg.sv ====
// Bus-side definitions for the AXI4 banked memory slave
// Widths, channel types and the beat-size helper
`default_nettype none

package axi_mem_pkg;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned LenWidth  = 8;

  localparam int unsigned MaxOutstanding = 4;  // Beats between request and response side

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [LenWidth-1:0]  len_t;
  typedef logic [2:0]           size_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Bytes moved by one beat of the given size
  function automatic addr_t beat_bytes(input size_t size);
    return addr_t'(1) << size;
  endfunction

endpackage

`default_nettype wire

// ==== bank_pkg.sv ====
// Bank-side definitions for the banked memory behind the AXI slave
// NumBanks sets how each bus word is split over the banks
`default_nettype none

package bank_pkg;

  localparam int unsigned NumBanks      = 2;
  localparam int unsigned BankDataWidth = axi_mem_pkg::DataWidth / NumBanks;
  localparam int unsigned BankStrbWidth = BankDataWidth / 8;
  localparam int unsigned BankAddrShift = $clog2(axi_mem_pkg::StrbWidth);  // Byte in bus word

  typedef logic [BankDataWidth-1:0] bank_data_t;
  typedef logic [BankStrbWidth-1:0] bank_strb_t;

endpackage

`default_nettype wire

// ==== mem_ifs.sv ====
// Internal links of the AXI memory slave
// meta_if carries one beat, word_if one word access and its response
`timescale 1ns/100ps
`default_nettype none

interface meta_if;
  import axi_mem_pkg::*;

  logic  valid;
  logic  ready;
  addr_t addr;   // Byte address of the beat
  id_t   id;
  logic  last;
  logic  write;

  modport source (output valid, addr, id, last, write, input ready);
  modport sink   (input valid, addr, id, last, write, output ready);
endinterface

interface word_if;
  import axi_mem_pkg::*;

  logic  req;
  logic  gnt;
  addr_t addr;
  data_t wdata;
  strb_t strb;
  logic  we;
  logic  rvalid;  // One pulse per accepted request, in order
  data_t rdata;

  modport master (output req, addr, wdata, strb, we, input gnt, rvalid, rdata);
  modport slave  (input req, addr, wdata, strb, we, output gnt, rvalid, rdata);
endinterface

`default_nettype wire

// ==== fall_through_reg.sv ====
// One-entry fall-through register
// Passes data straight through while empty, stores it when the output stalls
`timescale 1ns/100ps
`default_nettype none

module fall_through_reg #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  logic full_q;
  T     data_q;

  assign ready_o = !full_q;
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !ready_i;
    end else begin
      full_q <= valid_i && !ready_i;  // Capture on a stalled pass-through
    end
  end

  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== burst_ctrl.sv ====
// Burst controller
// Turns AR and AW bursts into single beats and arbitrates them round-robin
`timescale 1ns/100ps
`default_nettype none

module burst_ctrl (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                ar_valid_i,
  output logic                     ar_ready_o,
  input  wire axi_mem_pkg::addr_t  ar_addr_i,
  input  wire axi_mem_pkg::id_t    ar_id_i,
  input  wire axi_mem_pkg::len_t   ar_len_i,
  input  wire axi_mem_pkg::size_t  ar_size_i,
  input  wire axi_mem_pkg::burst_e ar_burst_i,
  input  wire logic                aw_valid_i,
  output logic                     aw_ready_o,
  input  wire axi_mem_pkg::addr_t  aw_addr_i,
  input  wire axi_mem_pkg::id_t    aw_id_i,
  input  wire axi_mem_pkg::len_t   aw_len_i,
  input  wire axi_mem_pkg::size_t  aw_size_i,
  input  wire axi_mem_pkg::burst_e aw_burst_i,
  input  wire logic                w_valid_i,
  output logic                     w_ready_o,
  meta_if.source                   beat_o,
  output logic                     wr_active_o,
  output logic                     rd_active_o
);
  import axi_mem_pkg::*;

  // Channel 0 is read, channel 1 is write
  logic  [1:0] ax_valid, ax_ready, gate, beat_valid, beat_ready, beat_last;
  addr_t [1:0] ax_addr, beat_addr, base_d, base_q;
  id_t   [1:0] ax_id, beat_id, id_d, id_q;
  len_t  [1:0] ax_len, cnt_d, cnt_q;
  size_t [1:0] ax_size, size_d, size_q;
  logic        sel, lock_q, lock_sel_q, rr_q;

  assign ax_valid = {aw_valid_i, ar_valid_i};
  assign ax_addr  = {aw_addr_i, ar_addr_i};
  assign ax_id    = {aw_id_i, ar_id_i};
  assign ax_len   = {aw_len_i, ar_len_i};
  assign ax_size  = {aw_size_i, ar_size_i};
  assign gate     = {w_valid_i, 1'b1};  // A write beat needs its W data

  // Pending beat of each channel, from state and inputs only
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      beat_valid[c] = 1'b0;
      beat_addr[c]  = base_q[c] + beat_bytes(size_q[c]);
      beat_id[c]    = id_q[c];
      beat_last[c]  = (cnt_q[c] == len_t'(1));
      if (cnt_q[c] != '0) begin
        beat_valid[c] = gate[c];
      end else if (ax_valid[c] && gate[c]) begin
        beat_valid[c] = 1'b1;
        beat_addr[c]  = ax_addr[c];  // First beat keeps the unaligned address
        beat_id[c]    = ax_id[c];
        beat_last[c]  = (ax_len[c] == '0);
      end
    end
  end

  // Next state once a beat has transferred
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      ax_ready[c] = beat_ready[c] && (cnt_q[c] == '0);
      cnt_d[c]    = cnt_q[c];
      base_d[c]   = base_q[c];
      id_d[c]     = id_q[c];
      size_d[c]   = size_q[c];
      if (ax_ready[c]) begin
        cnt_d[c]  = ax_len[c];
        base_d[c] = ax_addr[c] & ~(beat_bytes(ax_size[c]) - addr_t'(1));
        id_d[c]   = ax_id[c];
        size_d[c] = ax_size[c];
      end else if (beat_ready[c]) begin
        cnt_d[c]  = cnt_q[c] - len_t'(1);
        base_d[c] = beat_addr[c];
      end
    end
  end

  // An offered beat stays selected until it transfers
  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (&beat_valid) begin
      sel = rr_q;
    end else begin
      sel = beat_valid[1];
    end
  end

  assign beat_o.valid  = |beat_valid;
  assign beat_o.addr   = beat_addr[sel];
  assign beat_o.id     = beat_id[sel];
  assign beat_o.last   = beat_last[sel];
  assign beat_o.write  = sel;
  assign beat_ready[0] = beat_o.valid && beat_o.ready && !sel;
  assign beat_ready[1] = beat_o.valid && beat_o.ready && sel;

  assign ar_ready_o  = ax_ready[0];
  assign aw_ready_o  = ax_ready[1];
  assign w_ready_o   = beat_ready[1];  // Every write beat consumes one W
  assign rd_active_o = (cnt_q[0] != '0);
  assign wr_active_o = (cnt_q[1] != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      base_q     <= '0;
      id_q       <= '0;
      size_q     <= '0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
      rr_q       <= 1'b0;
    end else begin
      cnt_q      <= cnt_d;
      base_q     <= base_d;
      id_q       <= id_d;
      size_q     <= size_d;
      lock_q     <= beat_o.valid && !beat_o.ready;
      lock_sel_q <= sel;
      if (beat_o.valid && beat_o.ready) begin
        rr_q <= !sel;  // Other channel wins next tie
      end
    end
  end

  // Only INCR bursts are supported
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      ar_valid_i && ar_len_i != '0 |-> ar_burst_i == BURST_INCR)
    else $error("AR burst type other than INCR");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      aw_valid_i && aw_len_i != '0 |-> aw_burst_i == BURST_INCR)
    else $error("AW burst type other than INCR");

endmodule

`default_nettype wire

// ==== access_ctrl.sv ====
// Access controller
// Issues one word access per beat and returns the responses on R or B in order
`timescale 1ns/100ps
`default_nettype none

module access_ctrl (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  meta_if.sink                    beat_i,
  input  wire axi_mem_pkg::data_t w_data_i,
  input  wire axi_mem_pkg::strb_t w_strb_i,
  word_if.master                  mem_o,
  output logic                    r_valid_o,
  input  wire logic               r_ready_i,
  output axi_mem_pkg::data_t      r_data_o,
  output axi_mem_pkg::id_t        r_id_o,
  output logic                    r_last_o,
  output logic                    b_valid_o,
  input  wire logic               b_ready_i,
  output axi_mem_pkg::id_t        b_id_o
);
  import axi_mem_pkg::*;

  typedef struct packed {
    id_t  id;
    logic last;
    logic write;
  } meta_t;

  // One wrap bit above the entry index
  typedef logic [$clog2(MaxOutstanding):0] ptr_t;

  meta_t meta_mem [MaxOutstanding];
  data_t data_mem [MaxOutstanding];
  ptr_t  meta_wptr_q, data_wptr_q, rptr_q;
  meta_t head;
  logic  full, push, head_valid, pop;

  assign full = (ptr_t'(meta_wptr_q - rptr_q) == ptr_t'(MaxOutstanding));

  assign mem_o.req    = beat_i.valid && !full;
  assign beat_i.ready = mem_o.gnt && !full;
  assign push         = mem_o.req && mem_o.gnt;
  assign mem_o.addr   = beat_i.addr;
  assign mem_o.wdata  = w_data_i;
  assign mem_o.strb   = w_strb_i;
  assign mem_o.we     = beat_i.write;

  // Head is complete once its memory response is in
  assign head       = meta_mem[rptr_q[$bits(ptr_t)-2:0]];
  assign head_valid = (data_wptr_q != rptr_q);

  assign r_valid_o = head_valid && !head.write;
  assign r_data_o  = data_mem[rptr_q[$bits(ptr_t)-2:0]];
  assign r_id_o    = head.id;
  assign r_last_o  = head.last;
  assign b_valid_o = head_valid && head.write && head.last;
  assign b_id_o    = head.id;

  // Non-last write beats leave without a channel handshake
  assign pop = head_valid && (head.write ? (!head.last || b_ready_i) : r_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_wptr_q <= '0;
      data_wptr_q <= '0;
      rptr_q      <= '0;
    end else begin
      if (push) begin
        meta_wptr_q <= meta_wptr_q + ptr_t'(1);
      end
      if (mem_o.rvalid) begin
        data_wptr_q <= data_wptr_q + ptr_t'(1);
      end
      if (pop) begin
        rptr_q <= rptr_q + ptr_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      meta_mem[meta_wptr_q[$bits(ptr_t)-2:0]] <= '{id: beat_i.id, last: beat_i.last,
                                                   write: beat_i.write};
    end
    if (mem_o.rvalid) begin
      data_mem[data_wptr_q[$bits(ptr_t)-2:0]] <= mem_o.rdata;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_id_o)
                                  && $stable(r_last_o))
    else $error("R changed before its handshake");

endmodule

`default_nettype wire

// ==== bank_split.sv ====
// Bank splitter
// Spreads each bus word over the banks and joins their responses again
`timescale 1ns/100ps
`default_nettype none

module bank_split (
  input  wire logic                                            clk_i,
  input  wire logic                                            rst_ni,
  word_if.slave                                                mem_i,
  output logic                 [bank_pkg::NumBanks-1:0]        bank_req_o,
  input  wire logic            [bank_pkg::NumBanks-1:0]        bank_gnt_i,
  output axi_mem_pkg::addr_t   [bank_pkg::NumBanks-1:0]        bank_addr_o,
  output bank_pkg::bank_data_t [bank_pkg::NumBanks-1:0]        bank_wdata_o,
  output bank_pkg::bank_strb_t [bank_pkg::NumBanks-1:0]        bank_strb_o,
  output logic                 [bank_pkg::NumBanks-1:0]        bank_we_o,
  input  wire logic            [bank_pkg::NumBanks-1:0]        bank_rvalid_i,
  input  wire bank_pkg::bank_data_t [bank_pkg::NumBanks-1:0]   bank_rdata_i
);
  import axi_mem_pkg::*;
  import bank_pkg::*;

  typedef struct packed {
    addr_t      addr;
    bank_data_t wdata;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

  bank_req_t [NumBanks-1:0] bank_in, bank_out;
  logic      [NumBanks-1:0] req_ready, resp_ready, resp_valid;
  logic                     req_valid;
  addr_t                    word_addr;

  assign word_addr = (mem_i.addr >> BankAddrShift) << BankAddrShift;

  // Accept only when every bank can take the request and its response
  assign mem_i.gnt = (&req_ready) & (&resp_ready);
  assign req_valid = mem_i.req & mem_i.gnt;

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    assign bank_in[i].addr  = word_addr + addr_t'(i * BankStrbWidth);
    assign bank_in[i].wdata = mem_i.wdata[i*BankDataWidth +: BankDataWidth];
    assign bank_in[i].strb  = mem_i.strb[i*BankStrbWidth +: BankStrbWidth];
    assign bank_in[i].we    = mem_i.we;

    fall_through_reg #(.T(bank_req_t)) i_req_reg (
      .clk_i,
      .rst_ni,
      .valid_i (req_valid),
      .ready_o (req_ready[i]),
      .data_i  (bank_in[i]),
      .valid_o (bank_req_o[i]),
      .ready_i (bank_gnt_i[i]),
      .data_o  (bank_out[i])
    );

    assign bank_addr_o[i]  = bank_out[i].addr;
    assign bank_wdata_o[i] = bank_out[i].wdata;
    assign bank_strb_o[i]  = bank_out[i].strb;
    assign bank_we_o[i]    = bank_out[i].we;

    // Holds an early bank response until the slowest bank answers
    fall_through_reg #(.T(bank_data_t)) i_resp_reg (
      .clk_i,
      .rst_ni,
      .valid_i (bank_rvalid_i[i]),
      .ready_o (resp_ready[i]),
      .data_i  (bank_rdata_i[i]),
      .valid_o (resp_valid[i]),
      .ready_i (mem_i.rvalid),
      .data_o  (mem_i.rdata[i*BankDataWidth +: BankDataWidth])
    );
  end

  assign mem_i.rvalid = &resp_valid;

endmodule

`default_nettype wire

// ==== axi_mem_top.sv ====
// AXI4 slave onto a banked word memory
// Burst control, word access and bank split chained by internal links
`timescale 1ns/100ps
`default_nettype none

module axi_mem_top (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  input  wire logic                                          aw_valid_i,
  output logic                                               aw_ready_o,
  input  wire axi_mem_pkg::addr_t                            aw_addr_i,
  input  wire axi_mem_pkg::id_t                              aw_id_i,
  input  wire axi_mem_pkg::len_t                             aw_len_i,
  input  wire axi_mem_pkg::size_t                            aw_size_i,
  input  wire axi_mem_pkg::burst_e                           aw_burst_i,
  input  wire logic                                          w_valid_i,
  output logic                                               w_ready_o,
  input  wire axi_mem_pkg::data_t                            w_data_i,
  input  wire axi_mem_pkg::strb_t                            w_strb_i,
  input  wire logic                                          w_last_i,
  output logic                                               b_valid_o,
  input  wire logic                                          b_ready_i,
  output axi_mem_pkg::id_t                                   b_id_o,
  output axi_mem_pkg::resp_e                                 b_resp_o,
  input  wire logic                                          ar_valid_i,
  output logic                                               ar_ready_o,
  input  wire axi_mem_pkg::addr_t                            ar_addr_i,
  input  wire axi_mem_pkg::id_t                              ar_id_i,
  input  wire axi_mem_pkg::len_t                             ar_len_i,
  input  wire axi_mem_pkg::size_t                            ar_size_i,
  input  wire axi_mem_pkg::burst_e                           ar_burst_i,
  output logic                                               r_valid_o,
  input  wire logic                                          r_ready_i,
  output axi_mem_pkg::data_t                                 r_data_o,
  output axi_mem_pkg::id_t                                   r_id_o,
  output axi_mem_pkg::resp_e                                 r_resp_o,
  output logic                                               r_last_o,
  output logic                                               busy_o,
  output logic                      [bank_pkg::NumBanks-1:0] bank_req_o,
  input  wire logic                 [bank_pkg::NumBanks-1:0] bank_gnt_i,
  output axi_mem_pkg::addr_t        [bank_pkg::NumBanks-1:0] bank_addr_o,
  output bank_pkg::bank_data_t      [bank_pkg::NumBanks-1:0] bank_wdata_o,
  output bank_pkg::bank_strb_t      [bank_pkg::NumBanks-1:0] bank_strb_o,
  output logic                      [bank_pkg::NumBanks-1:0] bank_we_o,
  input  wire logic                 [bank_pkg::NumBanks-1:0] bank_rvalid_i,
  input  wire bank_pkg::bank_data_t [bank_pkg::NumBanks-1:0] bank_rdata_i
);
  import axi_mem_pkg::*;

  meta_if beat ();
  word_if mem ();
  logic   wr_active, rd_active;

  assign b_resp_o = RESP_OKAY;
  assign r_resp_o = RESP_OKAY;

  assign busy_o = aw_valid_i | ar_valid_i | w_valid_i | b_valid_o | r_valid_o |
                  wr_active | rd_active;

  burst_ctrl i_burst_ctrl (
    .clk_i, .rst_ni,
    .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_id_i, .ar_len_i, .ar_size_i, .ar_burst_i,
    .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_id_i, .aw_len_i, .aw_size_i, .aw_burst_i,
    .w_valid_i, .w_ready_o,
    .beat_o      (beat),
    .wr_active_o (wr_active),
    .rd_active_o (rd_active)
  );

  access_ctrl i_access_ctrl (
    .clk_i, .rst_ni,
    .beat_i (beat),
    .w_data_i, .w_strb_i,
    .mem_o  (mem),
    .r_valid_o, .r_ready_i, .r_data_o, .r_id_o, .r_last_o,
    .b_valid_o, .b_ready_i, .b_id_o
  );

  bank_split i_bank_split (
    .clk_i, .rst_ni,
    .mem_i (mem),
    .bank_req_o, .bank_gnt_i, .bank_addr_o, .bank_wdata_o, .bank_strb_o, .bank_we_o,
    .bank_rvalid_i, .bank_rdata_i
  );

endmodule

`default_nettype wire

// ==== tb_bank_model.sv ====
// Behavioural banked memory for the AXI memory testbench
// Grants follow an enable mask, read data returns one cycle after the grant
`timescale 1ns/100ps
`default_nettype none

module tb_bank_model (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  input  wire logic                 [bank_pkg::NumBanks-1:0] grant_en_i,
  input  wire logic                 [bank_pkg::NumBanks-1:0] req_i,
  output logic                      [bank_pkg::NumBanks-1:0] gnt_o,
  input  wire axi_mem_pkg::addr_t   [bank_pkg::NumBanks-1:0] addr_i,
  input  wire bank_pkg::bank_data_t [bank_pkg::NumBanks-1:0] wdata_i,
  input  wire bank_pkg::bank_strb_t [bank_pkg::NumBanks-1:0] strb_i,
  input  wire logic                 [bank_pkg::NumBanks-1:0] we_i,
  output logic                      [bank_pkg::NumBanks-1:0] rvalid_o,
  output bank_pkg::bank_data_t      [bank_pkg::NumBanks-1:0] rdata_o
);
  import axi_mem_pkg::*;
  import bank_pkg::*;

  localparam int unsigned Words = 1 << (AddrWidth - BankAddrShift);

  // One bus word index per bank entry
  bank_data_t mem [NumBanks][Words];

  assign gnt_o = req_i & grant_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= '0;
    end else begin
      rvalid_o <= gnt_o;  // Writes answer as well
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumBanks; i++) begin
      if (gnt_o[i]) begin
        if (we_i[i]) begin
          for (int b = 0; b < BankStrbWidth; b++) begin
            if (strb_i[i][b]) begin
              mem[i][addr_i[i][AddrWidth-1:BankAddrShift]][8*b +: 8] <= wdata_i[i][8*b +: 8];
            end
          end
        end
        rdata_o[i] <= mem[i][addr_i[i][AddrWidth-1:BankAddrShift]];  // Old word on a write
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
// Testbench for the AXI4 banked memory slave
// Directed bursts against a shadow memory, random bank grants and ready
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem;
  import axi_mem_pkg::*;
  import bank_pkg::*;

  // About 75 beats in all tests, each well under 50 cycles with random stalls
  localparam int unsigned TestBeats     = 80;
  localparam int unsigned TimeoutCycles = TestBeats * 50;

  logic   clk_i, rst_ni, busy_o;
  logic   aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i, b_valid_o, b_ready_i;
  logic   ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
  addr_t  aw_addr_i, ar_addr_i;
  id_t    aw_id_i, ar_id_i, b_id_o, r_id_o;
  len_t   aw_len_i, ar_len_i;
  size_t  aw_size_i, ar_size_i;
  burst_e aw_burst_i, ar_burst_i;
  data_t  w_data_i, r_data_o;
  strb_t  w_strb_i;
  resp_e  b_resp_o, r_resp_o;

  logic       [NumBanks-1:0] bank_req_o, bank_gnt_i, bank_we_o, bank_rvalid_i, gnt_en;
  addr_t      [NumBanks-1:0] bank_addr_o;
  bank_data_t [NumBanks-1:0] bank_wdata_o, bank_rdata_i;
  bank_strb_t [NumBanks-1:0] bank_strb_o;

  data_t       exp_r_data [$];  // Expected R beats in order
  id_t         exp_r_id [$];
  logic        exp_r_last [$];
  id_t         exp_b_id [$];
  data_t       shadow [addr_t];  // Keyed by bus word index
  string       test_name;
  logic [15:0] data_tag;
  logic        random_ready;
  logic [31:0] rnd_state;
  int unsigned value_errors, stray_beats, other_errors, busy_cycles;

  axi_mem_top i_axi_mem_top (.*);

  tb_bank_model i_bank_model (
    .clk_i, .rst_ni,
    .grant_en_i (gnt_en),
    .req_i      (bank_req_o),
    .gnt_o      (bank_gnt_i),
    .addr_i     (bank_addr_o),
    .wdata_i    (bank_wdata_o),
    .strb_i     (bank_strb_o),
    .we_i       (bank_we_o),
    .rvalid_o   (bank_rvalid_i),
    .rdata_o    (bank_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bank grants about 3 in 4 cycles, R and B ready random when enabled
  initial begin
    rnd_state = 32'd60811;
    gnt_en    = '0;
    r_ready_i = 1'b1;
    b_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      rnd_state = xorshift(rnd_state);
      gnt_en    = rnd_state[NumBanks-1:0] | rnd_state[NumBanks+7:8];
      r_ready_i = random_ready ? rnd_state[16] : 1'b1;
      b_ready_i = random_ready ? rnd_state[17] : 1'b1;
    end
  end

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Fail %s %s: expected %h, got %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_id(input string what, input id_t exp, input id_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Fail %s %s: expected %h, got %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input resp_e exp, input resp_e act);
    if (act !== exp) begin
      value_errors++;
      $display("Fail %s %s: expected %s, got %s", test_name, what, exp.name(), act.name());
    end
  endtask

  task automatic check_last(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Fail %s %s: expected %b, got %b", test_name, what, exp, act);
    end
  endtask

  // Handshakes are sampled mid-cycle and complete at the next rising edge
  initial begin
    value_errors = 0;
    stray_beats  = 0;
    busy_cycles  = 0;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (busy_o) busy_cycles++;
        if (r_valid_o && r_ready_i) begin
          if (exp_r_data.size() == 0) begin
            stray_beats++;
            $display("R beat with id %h arrived with no read outstanding", r_id_o);
          end else begin
            check_data("r_data", exp_r_data.pop_front(), r_data_o);
            check_id("r_id", exp_r_id.pop_front(), r_id_o);
            check_last("r_last", exp_r_last.pop_front(), r_last_o);
            check_resp("r_resp", RESP_OKAY, r_resp_o);
          end
        end
        if (b_valid_o && b_ready_i) begin
          if (exp_b_id.size() == 0) begin
            stray_beats++;
            $display("B with id %h arrived with no write outstanding", b_id_o);
          end else begin
            check_id("b_id", exp_b_id.pop_front(), b_id_o);
            check_resp("b_resp", RESP_OKAY, b_resp_o);
          end
        end
      end
    end
  end

  // Byte lanes of one beat, from its address up to the end of its size
  function automatic strb_t lane_strobe(input addr_t beat_addr, input size_t size);
    strb_t strb;
    int    lo, nb;
    nb   = int'(beat_bytes(size));
    lo   = int'(beat_addr) % int'(StrbWidth);
    strb = '0;
    for (int b = lo; b < (lo / nb + 1) * nb; b++) begin
      strb[b] = 1'b1;
    end
    return strb;
  endfunction

  task automatic store_shadow(input addr_t beat_addr, input data_t data, input strb_t strb);
    addr_t word;
    data_t merged;
    word   = beat_addr >> BankAddrShift;
    merged = shadow.exists(word) ? shadow[word] : '0;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    shadow[word] = merged;
  endtask

  // AW goes out with the first W beat, mask trims the strobes
  task automatic write_burst(input addr_t addr, input id_t id, input len_t len,
                             input size_t size, input strb_t mask);
    addr_t base, beat_addr;
    strb_t strb;
    data_t data;
    base = addr & ~(beat_bytes(size) - addr_t'(1));
    exp_b_id.push_back(id);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = id;
    aw_len_i   = len;
    aw_size_i  = size;
    aw_burst_i = BURST_INCR;
    for (int k = 0; k <= int'(len); k++) begin
      beat_addr = (k == 0) ? addr : base + addr_t'(k) * beat_bytes(size);
      strb      = lane_strobe(beat_addr, size) & mask;
      data      = {data_tag, beat_addr, ~data_tag, ~beat_addr};
      data_tag++;
      store_shadow(beat_addr, data, strb);
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      w_last_i  = (k == int'(len));
      do begin
        @(negedge clk_i);
      end while (!w_ready_o);
      if (k == 0 && !aw_ready_o) begin
        other_errors++;
        $display("AW was not accepted together with the first W beat in %s", test_name);
      end
      @(posedge clk_i);
      #1;
      aw_valid_i = 1'b0;
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
  endtask

  task automatic read_burst(input addr_t addr, input id_t id, input len_t len,
                            input size_t size);
    addr_t base, beat_addr;
    base = addr & ~(beat_bytes(size) - addr_t'(1));
    for (int k = 0; k <= int'(len); k++) begin
      beat_addr = (k == 0) ? addr : base + addr_t'(k) * beat_bytes(size);
      exp_r_data.push_back(shadow[beat_addr >> BankAddrShift]);  // Whole bus word returns
      exp_r_id.push_back(id);
      exp_r_last.push_back(k == int'(len));
    end
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = id;
    ar_len_i   = len;
    ar_size_i  = size;
    ar_burst_i = BURST_INCR;
    do begin
      @(negedge clk_i);
    end while (!ar_ready_o);
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    while (exp_r_data.size() != 0 || exp_b_id.size() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    if (ar_ready_o || aw_ready_o || w_ready_o || r_valid_o || b_valid_o || busy_o
        || bank_req_o != '0) begin
      other_errors++;
      $display("Handshake or busy outputs are not low after reset");
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_single_beat();
    test_name = "single_beat";
    write_burst(16'h0040, 4'h3, 8'd0, 3'd3, '1);
    wait_responses();
    read_burst(16'h0040, 4'h3, 8'd0, 3'd3);
    wait_responses();
  endtask

  task automatic test_strobes();
    test_name = "strobes";
    write_burst(16'h0080, 4'h1, 8'd0, 3'd3, '1);
    write_burst(16'h0080, 4'h2, 8'd0, 3'd3, 8'hA5);  // Lanes 1, 3, 4 and 6 keep the first word
    wait_responses();
    read_burst(16'h0080, 4'h2, 8'd0, 3'd3);
    wait_responses();
  endtask

  task automatic test_incr_burst();
    test_name = "incr_burst";
    write_burst(16'h0100, 4'h1, 8'd7, 3'd3, '1);
    wait_responses();
    read_burst(16'h0100, 4'h2, 8'd7, 3'd3);
    wait_responses();
  endtask

  task automatic test_narrow_burst();
    test_name = "narrow_burst";
    write_burst(16'h0106, 4'h5, 8'd5, 3'd2, '1);  // Unaligned start
    wait_responses();
    read_burst(16'h0106, 4'h5, 8'd5, 3'd2);
    wait_responses();
  endtask

  task automatic test_backpressure();
    test_name    = "backpressure";
    random_ready = 1'b1;
    fork
      begin
        write_burst(16'h0200, 4'h4, 8'd7, 3'd3, '1);
        write_burst(16'h0240, 4'h6, 8'd3, 3'd3, '1);
      end
      begin
        read_burst(16'h0100, 4'h7, 8'd7, 3'd3);
        read_burst(16'h0110, 4'h8, 8'd3, 3'd2);
      end
    join
    wait_responses();
    random_ready = 1'b0;
    read_burst(16'h0200, 4'h9, 8'd11, 3'd3);  // Both write bursts back to back
    wait_responses();
  endtask

  task automatic test_idle();
    int unsigned busy_before;
    test_name   = "idle";
    busy_before = busy_cycles;
    write_burst(16'h0300, 4'hA, 8'd3, 3'd3, '1);
    read_burst(16'h0300, 4'hB, 8'd3, 3'd3);
    wait_responses();
    if (busy_cycles == busy_before) begin
      other_errors++;
      $display("busy_o never rose while bursts were open");
    end
    @(negedge clk_i);
    if (busy_o) begin
      other_errors++;
      $display("busy_o still high after all responses were taken");
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    int unsigned cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Errors: %0d value mismatches, %0d stray responses, %0d other",
             value_errors, stray_beats, other_errors);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    other_errors = 0;
    data_tag     = 16'h1000;
    random_ready = 1'b0;
    test_name    = "reset";
    rst_ni       = 1'b0;
    aw_valid_i   = 1'b0;
    aw_addr_i    = '0;
    aw_id_i      = '0;
    aw_len_i     = '0;
    aw_size_i    = '0;
    aw_burst_i   = BURST_INCR;
    w_valid_i    = 1'b0;
    w_data_i     = '0;
    w_strb_i     = '0;
    w_last_i     = 1'b0;
    ar_valid_i   = 1'b0;
    ar_addr_i    = '0;
    ar_id_i      = '0;
    ar_len_i     = '0;
    ar_size_i    = '0;
    ar_burst_i   = BURST_INCR;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_reset_state();
    test_single_beat();
    test_strobes();
    test_incr_burst();
    test_narrow_burst();
    test_backpressure();
    test_idle();
    $display("Errors: %0d value mismatches, %0d stray responses, %0d other",
             value_errors, stray_beats, other_errors);
    if (value_errors + stray_beats + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
axi_mem_pkg.sv
bank_pkg.sv
mem_ifs.sv
fall_through_reg.sv
burst_ctrl.sv
access_ctrl.sv
bank_split.sv
axi_mem_top.sv
tb_bank_model.sv
tb_axi_mem.sv

// ==== Makefile ====
# Verilator build and run of the AXI memory testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_mem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
